// ==== logic/pwm_map_pkg.sv ====
// PWM generator register map, reset words and register word layout for sequencers and bank
package pwm_map_pkg;

    localparam int addr_width = 16;
    localparam int word_width = 32;

    localparam logic [addr_width-1:0] global_ctrl_addr = 16'h0000;
    localparam logic [addr_width-1:0] chain_stride = 16'h0100;  // Chain n starts at stride*(n+1)

    // Register offsets inside one chain block
    localparam logic [addr_width-1:0] compare_high_offset = 16'd4;
    localparam logic [addr_width-1:0] deadtime_offset = 16'd8;
    localparam logic [addr_width-1:0] counter_stop_offset = 16'd16;
    localparam logic [addr_width-1:0] phase_shift_offset = 16'd20;
    localparam logic [addr_width-1:0] output_enable_offset = 16'd24;
    localparam logic [addr_width-1:0] deadtime_enable_offset = 16'd28;
    localparam logic [addr_width-1:0] chain_control_offset = 16'd32;

    localparam logic [word_width-1:0] global_idle_word = 32'h0000_1100;  // Counters stopped
    localparam logic [word_width-1:0] global_run_word = 32'h0000_1128;

    // Control registers use ctrl, timing registers use count
    typedef union packed {
        struct packed {
            logic [15:0] reserved;
            logic [7:0]  mode;
            logic [1:0]  spare;
            logic        counter_enable;
            logic        sync_enable;
            logic [3:0]  output_enable;
        } ctrl;
        struct packed {
            logic [15:0] reserved;
            logic [15:0] count;
        } count;
    } pwm_reg_word_t;

    function automatic logic [addr_width-1:0] chain_base(input logic [addr_width-1:0] chain);
        return chain_stride * (chain + 1'b1);
    endfunction

    // Timing value placed in the count view, reserved half zero
    function automatic logic [word_width-1:0] count_word(input logic [15:0] value);
        pwm_reg_word_t word;
        word = '0;
        word.count.count = value;
        return word;
    endfunction

endpackage

// ==== logic/modulator_pkg.sv ====
// Converter-level constants for the four-phase buck modulation controller
package modulator_pkg;

    localparam int n_phases = 4;
    localparam int phase_index_width = 2;
    localparam int count_width = 16;  // Period, duty and shift values

    // Fixed per-chain setup values
    localparam logic [count_width-1:0] deadtime_counts = 16'd5;
    localparam logic [count_width-1:0] chain_output_enable = 16'd3;  // Both outputs of the chain
    localparam logic [count_width-1:0] chain_deadtime_enable = 16'd1;
    localparam logic [count_width-1:0] chain_control_word = 16'd1;

    // Bus requester identifiers
    localparam logic req_config = 1'b0;
    localparam logic req_modulation = 1'b1;

endpackage

// ==== logic/chain_config_sequencer.sv ====
// Writes the global word, per-chain setup and phase shifts of the PWM generator on configure
`timescale 1ns/1ps

module chain_config_sequencer (
    input  logic clock,
    input  logic reset,
    input  logic configure,
    input  logic [modulator_pkg::count_width-1:0] period,
    input  logic [modulator_pkg::n_phases-1:0][modulator_pkg::count_width-1:0] phase_shifts,
    output logic cfg_req,
    output logic [pwm_map_pkg::addr_width-1:0] cfg_addr,
    output logic [pwm_map_pkg::word_width-1:0] cfg_data,
    input  logic cfg_ack,
    output logic config_done
);

    enum logic [1:0] {cfg_idle, cfg_request, cfg_release} state;
    enum logic [1:0] {step_global, step_chain, step_shift} step, nxt_step;

    logic [2:0] reg_count, nxt_reg;
    logic [modulator_pkg::phase_index_width-1:0] chain_count, nxt_chain;
    logic [modulator_pkg::count_width-1:0] period_q, nxt_value;
    logic [pwm_map_pkg::addr_width-1:0] nxt_offset;
    logic last_write;
    logic launch;

    assign last_write = (step == step_shift) && (chain_count == modulator_pkg::n_phases - 1);
    assign launch = ((state == cfg_idle) && configure) ||
                    ((state == cfg_release) && !cfg_ack && !last_write);

    // Position and contents of the write after the current one
    always_comb begin
        nxt_step = step;
        nxt_reg = reg_count;
        nxt_chain = chain_count;
        if (state == cfg_idle) begin
            nxt_step = step_global;
            nxt_reg = '0;
            nxt_chain = '0;
        end else begin
            case (step)
                step_global: nxt_step = step_chain;
                step_chain: begin
                    if (reg_count == 3'd4) begin  // Five setup registers per chain
                        nxt_reg = '0;
                        nxt_chain = chain_count + 1'b1;
                        if (chain_count == modulator_pkg::n_phases - 1)
                            nxt_step = step_shift;
                    end else begin
                        nxt_reg = reg_count + 1'b1;
                    end
                end
                default: nxt_chain = chain_count + 1'b1;
            endcase
        end
        case (nxt_reg)
            3'd0: begin
                nxt_offset = pwm_map_pkg::deadtime_offset;
                nxt_value = modulator_pkg::deadtime_counts;
            end
            3'd1: begin
                nxt_offset = pwm_map_pkg::counter_stop_offset;
                nxt_value = period_q;
            end
            3'd2: begin
                nxt_offset = pwm_map_pkg::output_enable_offset;
                nxt_value = modulator_pkg::chain_output_enable;
            end
            3'd3: begin
                nxt_offset = pwm_map_pkg::deadtime_enable_offset;
                nxt_value = modulator_pkg::chain_deadtime_enable;
            end
            default: begin
                nxt_offset = pwm_map_pkg::chain_control_offset;
                nxt_value = modulator_pkg::chain_control_word;
            end
        endcase
        if (nxt_step == step_shift) begin
            nxt_offset = pwm_map_pkg::phase_shift_offset;
            nxt_value = phase_shifts[nxt_chain];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= cfg_idle;
            step <= step_global;
            reg_count <= '0;
            chain_count <= '0;
            cfg_req <= 1'b0;
            config_done <= 1'b0;
        end else begin
            config_done <= 1'b0;
            if (state == cfg_idle && configure)
                period_q <= period;  // One period value per sequence
            if (state == cfg_request && cfg_ack) begin
                cfg_req <= 1'b0;
                state <= cfg_release;
            end
            if (state == cfg_release && !cfg_ack && last_write) begin
                config_done <= 1'b1;
                state <= cfg_idle;
            end
            if (launch) begin
                step <= nxt_step;
                reg_count <= nxt_reg;
                chain_count <= nxt_chain;
                if (nxt_step == step_global) begin
                    cfg_addr <= pwm_map_pkg::global_ctrl_addr;
                    cfg_data <= pwm_map_pkg::global_idle_word;
                end else begin
                    cfg_addr <= pwm_map_pkg::chain_base(nxt_chain) + nxt_offset;
                    cfg_data <= pwm_map_pkg::count_word(nxt_value);
                end
                cfg_req <= 1'b1;
                state <= cfg_request;
            end
        end
    end

endmodule

// ==== logic/modulation_sequencer.sv ====
// Issues start, stop and deferred duty writes to the PWM generator at run time
`timescale 1ns/1ps

module modulation_sequencer (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic stop,
    input  logic update,
    input  logic [modulator_pkg::count_width-1:0] duty,
    output logic mod_req,
    output logic [pwm_map_pkg::addr_width-1:0] mod_addr,
    output logic [pwm_map_pkg::word_width-1:0] mod_data,
    input  logic mod_ack,
    output logic mod_done,
    output logic modulator_status
);

    enum logic [1:0] {mod_idle, mod_request, mod_release} state;

    logic pending;    // Duty update waiting for a stopped modulator
    logic duty_pass;  // Current write belongs to a compare-high pass
    logic [modulator_pkg::phase_index_width-1:0] chain_count;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= mod_idle;
            mod_req <= 1'b0;
            mod_done <= 1'b0;
            modulator_status <= 1'b0;
            pending <= 1'b0;
            duty_pass <= 1'b0;
            chain_count <= '0;
        end else begin
            mod_done <= 1'b0;
            pending <= pending | update;
            case (state)
                mod_idle: begin
                    if (stop) begin
                        modulator_status <= 1'b0;
                        mod_addr <= pwm_map_pkg::global_ctrl_addr;
                        mod_data <= pwm_map_pkg::global_idle_word;
                        mod_req <= 1'b1;
                        state <= mod_request;
                    end else if (start) begin
                        modulator_status <= 1'b1;
                        mod_addr <= pwm_map_pkg::global_ctrl_addr;
                        mod_data <= pwm_map_pkg::global_run_word;
                        mod_req <= 1'b1;
                        state <= mod_request;
                    end else if (pending && !modulator_status) begin
                        pending <= update;  // A fresh strobe stays queued
                        duty_pass <= 1'b1;
                        chain_count <= '0;
                        mod_addr <= pwm_map_pkg::chain_base('0) + pwm_map_pkg::compare_high_offset;
                        mod_data <= pwm_map_pkg::count_word(duty);  // Held for the whole pass
                        mod_req <= 1'b1;
                        state <= mod_request;
                    end
                end
                mod_request: begin
                    if (mod_ack) begin
                        mod_req <= 1'b0;
                        state <= mod_release;
                    end
                end
                mod_release: begin
                    if (!mod_ack) begin
                        if (duty_pass && chain_count != modulator_pkg::n_phases - 1) begin
                            chain_count <= chain_count + 1'b1;
                            mod_addr <= pwm_map_pkg::chain_base(chain_count + 1'b1)
                                        + pwm_map_pkg::compare_high_offset;
                            mod_req <= 1'b1;
                            state <= mod_request;
                        end else begin
                            mod_done <= duty_pass;  // Start and stop finish silently
                            duty_pass <= 1'b0;
                            state <= mod_idle;
                        end
                    end
                end
                default: state <= mod_idle;
            endcase
        end
    end

endmodule

// ==== logic/write_arbiter.sv ====
// Merges the configuration and modulation write requests onto the PWM register bus
`timescale 1ns/1ps

module write_arbiter (
    input  logic clock,
    input  logic reset,
    input  logic cfg_req,
    input  logic [pwm_map_pkg::addr_width-1:0] cfg_addr,
    input  logic [pwm_map_pkg::word_width-1:0] cfg_data,
    output logic cfg_ack,
    input  logic mod_req,
    input  logic [pwm_map_pkg::addr_width-1:0] mod_addr,
    input  logic [pwm_map_pkg::word_width-1:0] mod_data,
    output logic mod_ack,
    output logic bus_req,
    output logic [pwm_map_pkg::addr_width-1:0] bus_addr,
    output logic [pwm_map_pkg::word_width-1:0] bus_data,
    input  logic bus_ack,
    output logic grant_owner
);

    logic busy;       // Grant held for one full handshake
    logic owner_req;
    logic cfg_owns;

    assign cfg_owns = (grant_owner == modulator_pkg::req_config);
    assign owner_req = cfg_owns ? cfg_req : mod_req;

    assign bus_req = busy && owner_req;
    assign bus_addr = cfg_owns ? cfg_addr : mod_addr;
    assign bus_data = cfg_owns ? cfg_data : mod_data;

    assign cfg_ack = busy && cfg_owns && bus_ack;
    assign mod_ack = busy && (grant_owner == modulator_pkg::req_modulation) && bus_ack;

    always_ff @(posedge clock) begin
        if (!reset) begin
            busy <= 1'b0;
            grant_owner <= modulator_pkg::req_config;
        end else if (!busy) begin
            if (cfg_req) begin  // Configuration has priority
                busy <= 1'b1;
                grant_owner <= modulator_pkg::req_config;
            end else if (mod_req) begin
                busy <= 1'b1;
                grant_owner <= modulator_pkg::req_modulation;
            end
        end else if (!owner_req && !bus_ack) begin
            busy <= 1'b0;  // Handshake back to rest
        end
    end

endmodule

// ==== logic/pwm_register_bank.sv ====
// Register bus slave holding the PWM generator words, with a combinational read port
`timescale 1ns/1ps

module pwm_register_bank (
    input  logic clock,
    input  logic reset,
    input  logic bus_req,
    input  logic [pwm_map_pkg::addr_width-1:0] bus_addr,
    input  logic [pwm_map_pkg::word_width-1:0] bus_data,
    output logic bus_ack,
    input  logic [pwm_map_pkg::addr_width-1:0] read_addr,
    output logic [pwm_map_pkg::word_width-1:0] read_data
);

    pwm_map_pkg::pwm_reg_word_t global_word;
    pwm_map_pkg::pwm_reg_word_t chain_regs
        [modulator_pkg::n_phases][pwm_map_pkg::chain_control_offset / 4 + 1];  // Word slots
    pwm_map_pkg::pwm_reg_word_t wr_word;
    pwm_map_pkg::pwm_reg_word_t stored_word;
    pwm_map_pkg::pwm_reg_word_t rd_word;

    function automatic logic mapped(input logic [pwm_map_pkg::addr_width-1:0] addr);
        logic [pwm_map_pkg::addr_width-1:0] block;
        logic [pwm_map_pkg::addr_width-1:0] offset;
        block = addr / pwm_map_pkg::chain_stride;
        offset = addr % pwm_map_pkg::chain_stride;
        return (block >= 1) && (block <= modulator_pkg::n_phases) &&
               (offset inside {pwm_map_pkg::compare_high_offset, pwm_map_pkg::deadtime_offset,
                               pwm_map_pkg::counter_stop_offset, pwm_map_pkg::phase_shift_offset,
                               pwm_map_pkg::output_enable_offset,
                               pwm_map_pkg::deadtime_enable_offset,
                               pwm_map_pkg::chain_control_offset});
    endfunction

    function automatic logic timing_reg(input logic [pwm_map_pkg::addr_width-1:0] addr);
        return (addr % pwm_map_pkg::chain_stride) inside {pwm_map_pkg::compare_high_offset,
            pwm_map_pkg::deadtime_offset, pwm_map_pkg::counter_stop_offset,
            pwm_map_pkg::phase_shift_offset};
    endfunction

    function automatic logic [modulator_pkg::phase_index_width-1:0] chain_of(
        input logic [pwm_map_pkg::addr_width-1:0] addr);
        logic [pwm_map_pkg::addr_width-1:0] block;
        block = addr / pwm_map_pkg::chain_stride - 1'b1;
        return block[modulator_pkg::phase_index_width-1:0];
    endfunction

    function automatic logic [3:0] slot_of(input logic [pwm_map_pkg::addr_width-1:0] addr);
        logic [pwm_map_pkg::addr_width-1:0] slot;
        slot = (addr % pwm_map_pkg::chain_stride) >> 2;
        return slot[3:0];
    endfunction

    always_comb begin
        wr_word = bus_data;
        stored_word = '0;
        if (timing_reg(bus_addr))
            stored_word.count.count = wr_word.count.count;  // Reserved half reads zero
        else
            stored_word.ctrl = wr_word.ctrl;
    end

    // Write happens on the edge that raises ack
    always_ff @(posedge clock) begin
        if (!reset) begin
            bus_ack <= 1'b0;
            global_word <= pwm_map_pkg::global_idle_word;
            chain_regs <= '{default: '0};
        end else if (bus_req && !bus_ack) begin
            bus_ack <= 1'b1;
            if (bus_addr == pwm_map_pkg::global_ctrl_addr)
                global_word.ctrl <= wr_word.ctrl;
            else if (mapped(bus_addr))
                chain_regs[chain_of(bus_addr)][slot_of(bus_addr)] <= stored_word;
        end else if (!bus_req && bus_ack) begin
            bus_ack <= 1'b0;
        end
    end

    always_comb begin
        rd_word = '0;  // Unmapped addresses read zero
        if (read_addr == pwm_map_pkg::global_ctrl_addr)
            rd_word = global_word;
        else if (mapped(read_addr))
            rd_word = chain_regs[chain_of(read_addr)][slot_of(read_addr)];
        read_data = rd_word;
    end

endmodule

// ==== logic/buck_modulation_controller.sv ====
// Top level of the buck modulation control, joining both sequencers, the arbiter and the bank
`timescale 1ns/1ps

module buck_modulation_controller (
    input  logic clock,
    input  logic reset,
    input  logic configure,
    input  logic start,
    input  logic stop,
    input  logic update,
    input  logic [modulator_pkg::count_width-1:0] period,
    input  logic [modulator_pkg::count_width-1:0] duty,
    input  logic [modulator_pkg::n_phases-1:0][modulator_pkg::count_width-1:0] phase_shifts,
    input  logic [pwm_map_pkg::addr_width-1:0] read_addr,
    output logic config_done,
    output logic mod_done,
    output logic modulator_status,
    output logic [pwm_map_pkg::word_width-1:0] read_data
);

    logic cfg_req;
    logic cfg_ack;
    logic [pwm_map_pkg::addr_width-1:0] cfg_addr;
    logic [pwm_map_pkg::word_width-1:0] cfg_data;
    logic mod_req;
    logic mod_ack;
    logic [pwm_map_pkg::addr_width-1:0] mod_addr;
    logic [pwm_map_pkg::word_width-1:0] mod_data;
    logic bus_req;
    logic bus_ack;
    logic [pwm_map_pkg::addr_width-1:0] bus_addr;
    logic [pwm_map_pkg::word_width-1:0] bus_data;
    logic grant_owner;  // Observed by the bus assertions

    chain_config_sequencer u_config (
        .clock(clock), .reset(reset), .configure(configure),
        .period(period), .phase_shifts(phase_shifts),
        .cfg_req(cfg_req), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .cfg_ack(cfg_ack), .config_done(config_done)
    );

    modulation_sequencer u_modulation (
        .clock(clock), .reset(reset), .start(start), .stop(stop),
        .update(update), .duty(duty),
        .mod_req(mod_req), .mod_addr(mod_addr), .mod_data(mod_data),
        .mod_ack(mod_ack), .mod_done(mod_done), .modulator_status(modulator_status)
    );

    write_arbiter u_arbiter (
        .clock(clock), .reset(reset),
        .cfg_req(cfg_req), .cfg_addr(cfg_addr), .cfg_data(cfg_data), .cfg_ack(cfg_ack),
        .mod_req(mod_req), .mod_addr(mod_addr), .mod_data(mod_data), .mod_ack(mod_ack),
        .bus_req(bus_req), .bus_addr(bus_addr), .bus_data(bus_data), .bus_ack(bus_ack),
        .grant_owner(grant_owner)
    );

    pwm_register_bank u_bank (
        .clock(clock), .reset(reset),
        .bus_req(bus_req), .bus_addr(bus_addr), .bus_data(bus_data), .bus_ack(bus_ack),
        .read_addr(read_addr), .read_data(read_data)
    );

endmodule

// ==== tests/modulation_sva.sv ====
// Protocol checks on the arbiter links and bus, bound into every write_arbiter instance
`timescale 1ns/1ps

module modulation_assertions (
    input logic clock,
    input logic reset,
    input logic cfg_req,
    input logic [pwm_map_pkg::addr_width-1:0] cfg_addr,
    input logic [pwm_map_pkg::word_width-1:0] cfg_data,
    input logic cfg_ack,
    input logic mod_req,
    input logic [pwm_map_pkg::addr_width-1:0] mod_addr,
    input logic [pwm_map_pkg::word_width-1:0] mod_data,
    input logic mod_ack,
    input logic bus_req,
    input logic [pwm_map_pkg::addr_width-1:0] bus_addr,
    input logic [pwm_map_pkg::word_width-1:0] bus_data,
    input logic bus_ack,
    input logic grant_owner
);

    // Requests held until acknowledged
    cfg_req_held: assert property (@(posedge clock) disable iff (!reset)
        cfg_req && !cfg_ack |=> cfg_req)
        else $error("cfg_req dropped before cfg_ack");
    mod_req_held: assert property (@(posedge clock) disable iff (!reset)
        mod_req && !mod_ack |=> mod_req)
        else $error("mod_req dropped before mod_ack");
    bus_req_held: assert property (@(posedge clock) disable iff (!reset)
        bus_req && !bus_ack |=> bus_req)
        else $error("bus_req dropped before bus_ack");

    // Address and data frozen for the whole handshake
    cfg_stable: assert property (@(posedge clock) disable iff (!reset)
        (cfg_req || cfg_ack) && $past(cfg_req || cfg_ack)
            |-> $stable(cfg_addr) && $stable(cfg_data))
        else $error("cfg address or data changed during a handshake");
    mod_stable: assert property (@(posedge clock) disable iff (!reset)
        (mod_req || mod_ack) && $past(mod_req || mod_ack)
            |-> $stable(mod_addr) && $stable(mod_data))
        else $error("mod address or data changed during a handshake");
    bus_stable: assert property (@(posedge clock) disable iff (!reset)
        (bus_req || bus_ack) && $past(bus_req || bus_ack)
            |-> $stable(bus_addr) && $stable(bus_data))
        else $error("bus address or data changed during a handshake");

    one_ack: assert property (@(posedge clock) disable iff (!reset)
        !(cfg_ack && mod_ack))
        else $error("both requesters acknowledged at once");

    grant_held: assert property (@(posedge clock) disable iff (!reset)
        bus_req || bus_ack |=> $stable(grant_owner))
        else $error("grant changed in the middle of a bus transfer");

endmodule

bind write_arbiter modulation_assertions u_sva (
    .clock(clock), .reset(reset),
    .cfg_req(cfg_req), .cfg_addr(cfg_addr), .cfg_data(cfg_data), .cfg_ack(cfg_ack),
    .mod_req(mod_req), .mod_addr(mod_addr), .mod_data(mod_data), .mod_ack(mod_ack),
    .bus_req(bus_req), .bus_addr(bus_addr), .bus_data(bus_data), .bus_ack(bus_ack),
    .grant_owner(grant_owner)
);

// ==== tests/modulation_tb.sv ====
// Table-driven testbench for the buck modulation controller, reads back every register
`timescale 1ns/1ps

module modulation_tb;

    localparam int n_rows = 8;
    localparam int row_budget = 200;   // Watchdog cycles per table row
    localparam int quiet_cycles = 40;  // Window for rows that must finish nothing
    localparam logic [31:0] lfsr_seed = 32'h9deb01b6;
    localparam logic [31:0] lfsr_taps = 32'h80200003;

    typedef struct packed {
        logic       configure;
        logic       start;
        logic       stop;
        logic       update;
        logic       fresh_duty;  // New duty driven with the strobes
        logic       status;      // modulator_status after the row
        logic [1:0] cfg_dones;
        logic [1:0] mod_dones;
        logic [3:0] mod_writes;
    } op_row_t;

    logic clock;
    logic reset;
    logic configure;
    logic start;
    logic stop;
    logic update;
    logic [modulator_pkg::count_width-1:0] period;
    logic [modulator_pkg::count_width-1:0] duty;
    logic [modulator_pkg::n_phases-1:0][modulator_pkg::count_width-1:0] phase_shifts;
    logic [pwm_map_pkg::addr_width-1:0] read_addr;
    logic config_done;
    logic mod_done;
    logic modulator_status;
    logic [pwm_map_pkg::word_width-1:0] read_data;

    op_row_t op_table [n_rows];
    logic [31:0] lfsr_state;
    logic [31:0] shadow_global;
    logic [31:0] shadow_regs [modulator_pkg::n_phases][7];  // Chain, offset index
    logic shadow_running;
    logic shadow_pending;
    logic [modulator_pkg::count_width-1:0] held_duty;
    int cfg_done_count = 0;
    int mod_done_count = 0;
    int mod_write_count = 0;
    logic mod_ack_seen = 1'b0;

    buck_modulation_controller u_dut (
        .clock(clock), .reset(reset), .configure(configure), .start(start),
        .stop(stop), .update(update), .period(period), .duty(duty),
        .phase_shifts(phase_shifts), .read_addr(read_addr),
        .config_done(config_done), .mod_done(mod_done),
        .modulator_status(modulator_status), .read_data(read_data)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        repeat ((n_rows + 1) * row_budget) @(posedge clock);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 (n_rows + 1) * row_budget);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    // Done pulses and modulation-side write acknowledges
    always @(posedge clock) begin
        if (config_done === 1'b1)
            cfg_done_count++;
        if (mod_done === 1'b1)
            mod_done_count++;
        if (u_dut.mod_ack === 1'b1 && mod_ack_seen !== 1'b1)
            mod_write_count++;
        mod_ack_seen = u_dut.mod_ack;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
    endfunction

    task automatic draw_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsr_state[0]};  // One step per bit
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic [15:0] offset_of(input int k);
        case (k)
            0: return pwm_map_pkg::compare_high_offset;
            1: return pwm_map_pkg::deadtime_offset;
            2: return pwm_map_pkg::counter_stop_offset;
            3: return pwm_map_pkg::phase_shift_offset;
            4: return pwm_map_pkg::output_enable_offset;
            5: return pwm_map_pkg::deadtime_enable_offset;
            default: return pwm_map_pkg::chain_control_offset;
        endcase
    endfunction

    function automatic logic [15:0] reg_addr(input int chain, input int k);
        return 16'(pwm_map_pkg::chain_stride * (chain + 1)) + offset_of(k);
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic load_table();
        // configure start stop update fresh_duty | status cfg_dones mod_dones mod_writes
        op_table[0] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd1, 2'd0, 4'd0};
        op_table[1] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 2'd0, 2'd1, 4'd4};  // Stopped
        op_table[2] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 2'd0, 2'd0, 4'd1};
        op_table[3] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 2'd0, 2'd0, 4'd0};  // Deferred
        op_table[4] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 2'd0, 2'd1, 4'd5};
        op_table[5] = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 2'd1, 2'd0, 4'd1};
        op_table[6] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 2'd0, 4'd1};
        op_table[7] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 2'd0, 2'd1, 4'd4};
    endtask

    task automatic duty_pass();
        for (int n = 0; n < modulator_pkg::n_phases; n++)
            shadow_regs[n][0] = {16'h0000, held_duty};
        shadow_pending = 1'b0;
    endtask

    task automatic read_word(input logic [15:0] addr, input logic [31:0] expected);
        @(posedge clock);
        read_addr <= addr;
        @(negedge clock);
        assert (read_data == expected)
            else report_mismatch($sformatf("read 0x%04h gave 0x%08h, expected 0x%08h",
                                           addr, read_data, expected));
    endtask

    task automatic check_registers();
        read_word(pwm_map_pkg::global_ctrl_addr, shadow_global);
        for (int n = 0; n < modulator_pkg::n_phases; n++)
            for (int k = 0; k < 7; k++)
                read_word(reg_addr(n, k), shadow_regs[n][k]);
    endtask

    task automatic run_row(input op_row_t row);
        logic [31:0] value;
        logic [modulator_pkg::count_width-1:0] new_period;
        logic [modulator_pkg::n_phases-1:0][modulator_pkg::count_width-1:0] new_shifts;
        int cfg_target;
        int done_target;
        int write_target;
        cfg_target = cfg_done_count + row.cfg_dones;
        done_target = mod_done_count + row.mod_dones;
        write_target = mod_write_count + row.mod_writes;
        new_period = period;
        new_shifts = phase_shifts;
        if (row.configure) begin
            draw_bits(16, value);
            new_period = value[15:0];
            for (int n = 0; n < modulator_pkg::n_phases; n++) begin
                draw_bits(16, value);
                new_shifts[n] = value[15:0];
            end
        end
        if (row.fresh_duty) begin
            draw_bits(16, value);
            held_duty = value[15:0];
        end
        @(posedge clock);
        configure <= row.configure;
        start <= row.start;
        stop <= row.stop;
        update <= row.update;
        period <= new_period;
        phase_shifts <= new_shifts;
        duty <= held_duty;
        @(posedge clock);
        configure <= 1'b0;
        start <= 1'b0;
        stop <= 1'b0;
        update <= 1'b0;

        // Shadow follows the map rules, configuration lands before a start
        if (row.configure) begin
            shadow_global = pwm_map_pkg::global_idle_word;
            for (int n = 0; n < modulator_pkg::n_phases; n++) begin
                shadow_regs[n][1] = {16'h0000, modulator_pkg::deadtime_counts};
                shadow_regs[n][2] = {16'h0000, new_period};
                shadow_regs[n][3] = {16'h0000, new_shifts[n]};
                shadow_regs[n][4] = {16'h0000, modulator_pkg::chain_output_enable};
                shadow_regs[n][5] = {16'h0000, modulator_pkg::chain_deadtime_enable};
                shadow_regs[n][6] = {16'h0000, modulator_pkg::chain_control_word};
            end
        end
        if (row.stop) begin
            shadow_running = 1'b0;
            shadow_global = pwm_map_pkg::global_idle_word;
            if (shadow_pending)
                duty_pass();
        end else if (row.start) begin
            shadow_running = 1'b1;
            shadow_global = pwm_map_pkg::global_run_word;
        end
        if (row.update) begin
            shadow_pending = 1'b1;
            if (!shadow_running)
                duty_pass();
        end

        if (row.cfg_dones == 0 && row.mod_dones == 0 && row.mod_writes == 0)
            repeat (quiet_cycles) @(negedge clock);
        while (cfg_done_count < cfg_target || mod_done_count < done_target ||
               mod_write_count < write_target)
            @(negedge clock);
        assert (cfg_done_count == cfg_target && mod_done_count == done_target &&
                mod_write_count == write_target)
            else report_mismatch($sformatf("counts cfg %0d mod %0d writes %0d, expected %0d %0d %0d",
                                           cfg_done_count, mod_done_count, mod_write_count,
                                           cfg_target, done_target, write_target));
        assert (modulator_status == row.status)
            else report_mismatch($sformatf("modulator_status %0b, expected %0b",
                                           modulator_status, row.status));
        check_registers();
        // Nothing may finish or write while the registers are swept
        assert (cfg_done_count == cfg_target && mod_done_count == done_target &&
                mod_write_count == write_target)
            else report_mismatch("extra done pulse or write during the register sweep");
    endtask

    initial begin
        reset = 1'b0;
        configure = 1'b0;
        start = 1'b0;
        stop = 1'b0;
        update = 1'b0;
        period = '0;
        duty = '0;
        phase_shifts = '0;
        read_addr = '0;
        held_duty = '0;
        lfsr_state = lfsr_seed;
        load_table();
        shadow_global = pwm_map_pkg::global_idle_word;
        shadow_regs = '{default: '0};
        shadow_running = 1'b0;
        shadow_pending = 1'b0;
        repeat (16) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        assert (modulator_status == 1'b0)
            else report_mismatch("modulator_status high after reset");
        check_registers();
        for (int i = 0; i < n_rows; i++)
            run_row(op_table[i]);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== build.f ====
logic/pwm_map_pkg.sv
logic/modulator_pkg.sv
logic/chain_config_sequencer.sv
logic/modulation_sequencer.sv
logic/write_arbiter.sv
logic/pwm_register_bank.sv
logic/buck_modulation_controller.sv
tests/modulation_sva.sv
tests/modulation_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run the testbench and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module modulation_tb -f build.f \
    -Mdir obj_dir -o modulation_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/modulation_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
